// File: build.f
sdPkg.sv
sdcSequencer.sv
sdcRegs.sv
spiShifter.sv
sdcTop.sv
tbClock.sv
sdcTb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module sdcTb -f build.f \
  && ./obj_dir/VsdcTb | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sdcTb.sv
// testbench for the SD card SPI access path
// SPI card model, expected results and protocol checks on the pins

`timescale 1ns/1ps
`default_nettype none

module sdcTb;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 5;
  localparam int DivFast     = 2;
  localparam int DivSlow     = 8;
  localparam int QuietCycles = 100;
  // bring-up and both transfers take a few hundred cycles at most
  localparam int CycleLimit  = 2000;

  logic       clk;
  logic       rst;
  logic       miso;
  logic       sclk;
  logic       mosi;
  logic       csN;
  logic [7:0] resultByte;
  logic       resultValid;
  logic       done;

  // card side
  logic [7:0]  responseByte [2];
  logic [7:0]  shiftIn = 8'h00;
  logic [7:0]  misoShift = 8'hFF;
  logic [31:0] randomDraw;
  int          risingCount = 0;
  int          capturedCount = 0;

  // bookkeeping for the checks
  int  edgeCount = 0;
  int  resultCount = 0;
  int  cycleCount = 0;
  int  errorCount = 0;
  int  edgesAtDone;
  time lastEdgeTime = 0;
  logic sawSelect = 1'b0;
  logic resetChecked = 1'b0;
  logic prevValid = 1'b0;

  tbClock #(
    .Period      (ClkPeriod),
    .ResetCycles (ResetCycles)
  ) tbClock_i (
    .clk (clk),
    .rst (rst)
  );

  sdcTop #(
    .DivFast (DivFast),
    .DivSlow (DivSlow)
  ) sdcTop_i (
    .clk         (clk),
    .rst         (rst),
    .miso        (miso),
    .sclk        (sclk),
    .mosi        (mosi),
    .csN         (csN),
    .resultByte  (resultByte),
    .resultValid (resultValid),
    .done        (done)
  );

  // byte the card answered for each reported result
  function automatic logic [7:0] expectedResult(input int index);
    return responseByte[index];
  endfunction

  // bytes the bring-up sends, in order
  function automatic logic [7:0] expectedMosi(input int index);
    return (index == 0) ? 8'hB1 : 8'hFF;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected)
    begin
      errorCount++;
      $display("Error: time %0t, %s = %0h, expected %0h", $time, name, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic abortRun(input string why);
    errorCount++;
    $display("Run stopped at time %0t: %s", $time, why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // card model, capture mosi on the rising edge
  always @(posedge sclk)
  begin
    if (!rst)
    begin
      checkValue("csN", 32'(csN), 32'd0);
      shiftIn = {shiftIn[6:0], mosi};
      risingCount = risingCount + 1;
      if (risingCount % 8 == 0)
      begin
        checkValue("mosiByte", 32'(shiftIn), 32'(expectedMosi(capturedCount)));
        capturedCount = capturedCount + 1;
      end
    end
  end

  // next response bit out on the falling edge
  always @(negedge sclk)
  begin
    if (!rst)
    begin
      if (risingCount % 8 == 0)
        misoShift = (capturedCount < 2) ? responseByte[capturedCount] : 8'hFF;
      else
        misoShift = {misoShift[6:0], 1'b1};
      miso <= misoShift[7];
    end
  end

  // half-period inside a byte, the gap between bytes is not checked
  always @(posedge sclk or negedge sclk)
  begin
    if (!rst)
    begin
      if (edgeCount % 16 != 0)
        checkValue("sclkHalfPeriod", 32'($time - lastEdgeTime), 32'(DivFast * ClkPeriod));
      lastEdgeTime = $time;
      edgeCount = edgeCount + 1;
    end
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (!resetChecked)
      begin
        checkValue("csN", 32'(csN), 32'd1);
        checkValue("sclk", 32'(sclk), 32'd0);
        checkValue("resultValid", 32'(resultValid), 32'd0);
        resetChecked = 1'b1;
      end
      if (!csN)
        sawSelect = 1'b1;
      else if (sawSelect && !done)
        abortRun("card deselected before the sequence finished");
      if (resultValid)
      begin
        if (prevValid)
          abortRun("resultValid stayed high for more than one cycle");
        if (resultCount >= capturedCount)
          abortRun("resultValid without a finished transfer");
        checkValue("resultByte", 32'(resultByte), 32'(expectedResult(resultCount)));
        resultCount = resultCount + 1;
      end
      prevValid = resultValid;
    end
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit)
      abortRun("timeout, the sequencer never finished");
  end

  initial
  begin
    void'($urandom(32'h3060_cdef));
    randomDraw = $urandom;
    responseByte[0] = randomDraw[7:0];
    randomDraw = $urandom;
    responseByte[1] = randomDraw[7:0];
    misoShift = responseByte[0];
    miso = responseByte[0][7];

    while (done !== 1'b1)
      @(negedge clk);
    checkValue("resultCount", 32'(resultCount), 32'd2);
    checkValue("capturedCount", 32'(capturedCount), 32'd2);
    checkValue("edgeCount", 32'(edgeCount), 32'd32);
    edgesAtDone = edgeCount;

    // nothing more may happen on the pins
    repeat (QuietCycles) @(negedge clk);
    checkValue("edgeCount", 32'(edgeCount), 32'(edgesAtDone));
    checkValue("resultCount", 32'(resultCount), 32'd2);
    checkValue("done", 32'(done), 32'd1);

    if (errorCount == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: tbClock.sv
// testbench clock and reset generator
// free-running clock, reset held high for a fixed number of cycles

`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int Period      = 4,
  parameter int ResetCycles = 5
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #(Period / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: sdcTop.sv
// SD card SPI access path top level
// sequencer, register block and shifter wired to the SPI pins

`timescale 1ns/1ps
`default_nettype none

module sdcTop
  import sdPkg::*;
#(
  parameter int DivFast = 2,
  parameter int DivSlow = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       miso,
  output logic       sclk,
  output logic       mosi,
  output logic       csN,
  output logic [7:0] resultByte,
  output logic       resultValid,
  output logic       done
);

  busReq_t     req;
  logic [31:0] rdata;
  logic        ack;
  logic        start;
  logic [7:0]  txByte;
  logic        fast;
  logic        busy;
  logic [7:0]  rxByte;

  sdcSequencer sdcSequencer_i (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .rdata       (rdata),
    .ack         (ack),
    .resultByte  (resultByte),
    .resultValid (resultValid),
    .done        (done)
  );

  sdcRegs sdcRegs_i (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .rdata  (rdata),
    .ack    (ack),
    .start  (start),
    .txByte (txByte),
    .fast   (fast),
    .busy   (busy),
    .rxByte (rxByte),
    .csN    (csN)
  );

  spiShifter #(
    .DivFast (DivFast),
    .DivSlow (DivSlow)
  ) spiShifter_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .txByte (txByte),
    .fast   (fast),
    .busy   (busy),
    .rxByte (rxByte),
    .sclk   (sclk),
    .mosi   (mosi),
    .miso   (miso)
  );

endmodule

`default_nettype wire

// File: spiShifter.sv
// SPI mode 0 byte shifter
// divides the system clock to sclk and moves eight bits each way, MSB first

`timescale 1ns/1ps
`default_nettype none

module spiShifter #(
  parameter int DivFast = 2,
  parameter int DivSlow = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic [7:0] txByte,
  input  logic       fast,
  output logic       busy,
  output logic [7:0] rxByte,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso
);

  localparam int DivMax = (DivFast > DivSlow) ? DivFast : DivSlow;
  localparam int CntW   = $clog2(DivMax + 1);

  logic [CntW-1:0] divCnt;
  logic [CntW-1:0] halfLimit;
  logic [3:0]      edgeCnt;
  logic [7:0]      txShift;
  logic            edgeNow;

  assign halfLimit = fast ? CntW'(DivFast - 1) : CntW'(DivSlow - 1);
  assign edgeNow   = busy && (divCnt == halfLimit);
  assign mosi      = txShift[7];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy    <= 1'b0;
      sclk    <= 1'b0;
      divCnt  <= '0;
      edgeCnt <= '0;
      txShift <= 8'hFF;
    end
    else if (start && !busy)
    begin
      busy    <= 1'b1;
      divCnt  <= '0;
      edgeCnt <= '0;
      txShift <= txByte;
    end
    else if (edgeNow)
    begin
      divCnt  <= '0;
      edgeCnt <= edgeCnt + 4'd1;
      sclk    <= ~sclk;
      // falling edge, next bit out or finish after the 16th edge
      if (sclk)
      begin
        if (edgeCnt == 4'd15)
          busy <= 1'b0;
        else
          txShift <= {txShift[6:0], 1'b1};
      end
    end
    else if (busy)
      divCnt <= divCnt + 1'b1;
  end

  // sample on rising edge
  always_ff @(posedge clk)
  begin
    if (edgeNow && !sclk)
      rxByte <= {rxByte[6:0], miso};
  end

  noStartWhileBusy: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy);

endmodule

`default_nettype wire

// File: sdcRegs.sv
// SD controller register block
// control register, transfer start and status/data readback

`timescale 1ns/1ps
`default_nettype none

module sdcRegs
  import sdPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  busReq_t     req,
  output logic [31:0] rdata,
  output logic        ack,
  output logic        start,
  output logic [7:0]  txByte,
  output logic        fast,
  input  logic        busy,
  input  logic [7:0]  rxByte,
  output logic        csN
);

  logic [1:0]  ctrlReg;
  logic [31:0] statusWord;
  logic        access;

  // first cycle of a bus cycle
  assign access = req.stb && !ack;

  always_comb
  begin
    statusWord                 = '0;
    statusWord[StatusReadyBit] = ~busy;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack     <= 1'b0;
      start   <= 1'b0;
      ctrlReg <= '0;
    end
    else
    begin
      ack   <= access;
      start <= 1'b0;
      if (access && req.we)
      begin
        if (req.addr == AddrCtrl)
        begin
          ctrlReg[CtrlSelBit]  <= req.wdata[CtrlSelBit];
          ctrlReg[CtrlFastBit] <= req.wdata[CtrlFastBit];
        end
        else if (!busy)
          start <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (access && req.we && req.addr == AddrData && !busy)
      txByte <= req.wdata[7:0];
    if (access && !req.we)
      rdata <= (req.addr == AddrCtrl) ? statusWord : {24'b0, rxByte};
  end

  assign csN  = ~ctrlReg[CtrlSelBit];
  assign fast = ctrlReg[CtrlFastBit];

  ackNeedsStb: assert property (@(posedge clk) disable iff (rst)
    ack |-> req.stb);

endmodule

`default_nettype wire

// File: sdcSequencer.sv
// SD card bring-up sequencer
// selects the card, sends two bytes and reports what comes back

`timescale 1ns/1ps
`default_nettype none

module sdcSequencer
  import sdPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  output busReq_t     req,
  input  logic [31:0] rdata,
  input  logic        ack,
  output logic [7:0]  resultByte,
  output logic        resultValid,
  output logic        done
);

  localparam logic [3:0] IdleCycles = 4'd10;

  seqState_t  state;
  logic [3:0] waitCnt;
  busReq_t    stepReq;

  // request belonging to the current step
  always_comb
  begin
    stepReq     = '0;
    stepReq.stb = 1'b1;
    case (state)
      SeqCtrl:
      begin
        stepReq.we                = 1'b1;
        stepReq.addr              = AddrCtrl;
        stepReq.wdata[CtrlSelBit]  = 1'b1;
        stepReq.wdata[CtrlFastBit] = 1'b1;
      end
      SeqSendB1:
      begin
        stepReq.we    = 1'b1;
        stepReq.addr  = AddrData;
        stepReq.wdata = 32'h0000_00B1;
      end
      SeqSendFf:
      begin
        stepReq.we    = 1'b1;
        stepReq.addr  = AddrData;
        stepReq.wdata = 32'h0000_00FF;
      end
      SeqPoll1, SeqPoll2:
        stepReq.addr = AddrCtrl;
      SeqRead1, SeqRead2:
        stepReq.addr = AddrData;
      default:
        stepReq = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= SeqWait;
      waitCnt     <= IdleCycles;
      req         <= '0;
      resultValid <= 1'b0;
      done        <= 1'b0;
    end
    else
    begin
      resultValid <= 1'b0;
      case (state)
        SeqWait:
          if (waitCnt != 4'd0)
            waitCnt <= waitCnt - 4'd1;
          else
            state <= SeqCtrl;
        SeqHalt:
          done <= 1'b1;
        default:
          if (!req.stb)
            req <= stepReq;
          else if (ack)
          begin
            // cycle finished so drop strobe and move on
            req <= '0;
            case (state)
              SeqCtrl:   state <= SeqSendB1;
              SeqSendB1: state <= SeqPoll1;
              SeqPoll1:  state <= rdata[StatusReadyBit] ? SeqRead1 : SeqPoll1;
              SeqRead1:  state <= SeqSendFf;
              SeqSendFf: state <= SeqPoll2;
              SeqPoll2:  state <= rdata[StatusReadyBit] ? SeqRead2 : SeqPoll2;
              default:   state <= SeqHalt;
            endcase
            if (state == SeqRead1 || state == SeqRead2)
            begin
              resultByte  <= rdata[7:0];
              resultValid <= 1'b1;
            end
          end
      endcase
    end
  end

  stbHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
    req.stb && !ack |=> req.stb && ack);

endmodule

`default_nettype wire

// File: sdPkg.sv
// SD card SPI access path shared definitions
// bus request, register map, control bits and sequencer steps

`default_nettype none

package sdPkg;

  // one request on the strobe bus
  typedef struct packed {
    logic        stb;
    logic        we;
    logic        addr;
    logic [31:0] wdata;
  } busReq_t;

  // register map
  localparam logic AddrCtrl = 1'b0;
  localparam logic AddrData = 1'b1;

  // control register bits
  localparam int CtrlSelBit  = 0;
  localparam int CtrlFastBit = 1;

  // status word, ready when shifter idle
  localparam int StatusReadyBit = 0;

  typedef enum logic [3:0] {
    SeqWait   = 4'd0,
    SeqCtrl   = 4'd1,
    SeqSendB1 = 4'd2,
    SeqPoll1  = 4'd3,
    SeqRead1  = 4'd4,
    SeqSendFf = 4'd5,
    SeqPoll2  = 4'd6,
    SeqRead2  = 4'd7,
    SeqHalt   = 4'd8
  } seqState_t;

endpackage

`default_nettype wire
